/* common/psramPkg.sv */
package psramPkg;

	// ----------------------------------------
	// Bus and counter widths
	// ----------------------------------------

	// USI register bus address width
	localparam int busAdrsBit = 16;

	// Master clock enable divider width
	localparam int divBit = 16;

	// One SPI frame word
	localparam int wordBit = 32;

	// Word count field in the frame header
	localparam int wordCntBit = wordBit - 2 - busAdrsBit;

	// ----------------------------------------
	// Frame commands
	// ----------------------------------------

	// Register bus write
	localparam logic [1:0] cmdUsiWrite = 2'd0;

	// Register bus read
	localparam logic [1:0] cmdUsiRead = 2'd1;

	// Stream bus write
	localparam logic [1:0] cmdUfiWrite = 2'd2;

	// Reserved code
	// frames carrying it are clocked through without bus activity
	localparam logic [1:0] cmdNone = 2'd3;

	// ----------------------------------------
	// Received frame word
	// ----------------------------------------

	// Same 32 shifted bits seen as header or as payload
	typedef union packed
	{
		// First word of a frame
		struct packed
		{
			logic [1:0] cmd;
			logic [wordCntBit-1:0] count;
			logic [busAdrsBit-1:0] adrs;
		} header;
		// Every later word
		logic [wordBit-1:0] data;
	} spiWordU;

endpackage

/* common/spiLinkIf.sv */
`timescale 1ns/1ps

interface spiLinkIf import psramPkg::*;;

	// Command of the open frame
	// cmdNone while no frame is open
	logic [1:0] cmd;

	// Address of the current data word
	logic [busAdrsBit-1:0] adrs;

	// Data word just received
	logic [wordBit-1:0] wd;

	// Single cycle strobes
	logic wEd;
	logic rEd;

	// Read back word for the host
	logic [wordBit-1:0] misoWord;

	// Frame receiver side
	modport frame (output cmd, output adrs, output wd, output wEd, output rEd,
		input misoWord);

	// Bus side
	modport bus (input cmd, input adrs, input wd, input wEd, input rEd,
		output misoWord);

endinterface

/* spiSignal/spiSlaveFrame.sv */
`timescale 1ns/1ps

module spiSlaveFrame import psramPkg::*;
(
	input  logic sysClk,
	input  logic rst,
	input  logic sck,
	input  logic mosi,
	input  logic cs,
	output logic miso,
	spiLinkIf.frame link
);

// ----------------------------------------
// Pin synchronizers and edges
// ----------------------------------------
logic [1:0] sckSync;
logic [1:0] mosiSync;
logic [1:0] csSync;
logic sckPrev;
logic csPrev;
logic sckRise;
logic sckFall;
logic csRise;

always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		sckSync <= 2'b00;
		mosiSync <= 2'b00;
		// Chip select idles high
		csSync <= 2'b11;
		sckPrev <= 1'b0;
		csPrev <= 1'b1;
	end
	else
	begin
		sckSync <= {sckSync[0], sck};
		mosiSync <= {mosiSync[0], mosi};
		csSync <= {csSync[0], cs};
		sckPrev <= sckSync[1];
		csPrev <= csSync[1];
	end
end

// Sck edges only count inside a frame
assign sckRise = sckSync[1] & ~sckPrev & ~csSync[1];
assign sckFall = ~sckSync[1] & sckPrev & ~csSync[1];
// End of frame
assign csRise = csSync[1] & ~csPrev;

// ----------------------------------------
// Receive shifter
// ----------------------------------------
spiWordU shiftReg;
spiWordU nextWord;

// Word as it stands once the current bit is in
always_comb
begin
	nextWord.data = {shiftReg.data[wordBit-2:0], mosiSync[1]};
end

always_ff @(posedge sysClk)
begin
	if (sckRise)
		shiftReg <= nextWord;
end

// ----------------------------------------
// Frame state
// ----------------------------------------
logic inHeader;
logic [4:0] bitIdx;
logic [wordCntBit-1:0] wordIdx;
logic [wordCntBit-1:0] wordCnt;
logic [1:0] cmdReg;
logic [busAdrsBit-1:0] adrsReg;
logic rEdReg;
logic wordEnd;
logic frameDone;

// Last bit of any 32 bit slot
assign wordEnd = sckRise & (bitIdx == 5'd31);
// Count reached so later bits are dropped
assign frameDone = (wordIdx == wordCnt);

always_ff @(posedge sysClk)
begin
	if (rst || csRise)
	begin
		inHeader <= 1'b1;
		bitIdx <= '0;
		wordIdx <= '0;
		wordCnt <= '0;
		cmdReg <= cmdNone;
		rEdReg <= 1'b0;
	end
	else
	begin
		rEdReg <= 1'b0;
		if (sckRise)
			bitIdx <= bitIdx + 5'd1;
		if (wordEnd && inHeader)
		begin
			// Header complete
			inHeader <= 1'b0;
			cmdReg <= nextWord.header.cmd;
			wordCnt <= nextWord.header.count;
			wordIdx <= '0;
			// Fetch the first read word right away
			rEdReg <= (nextWord.header.cmd == cmdUsiRead) && (nextWord.header.count != '0);
		end
		else if (wordEnd && !frameDone)
		begin
			wordIdx <= wordIdx + 1'b1;
			// Prefetch the following word unless this was the last
			rEdReg <= (cmdReg == cmdUsiRead) && (wordIdx + 1'b1 != wordCnt);
		end
	end
end

// Word address walks up one per slot
always_ff @(posedge sysClk)
begin
	if (wordEnd && inHeader)
		adrsReg <= nextWord.header.adrs;
	else if (wordEnd && !frameDone)
		adrsReg <= adrsReg + 1'b1;
end

// ----------------------------------------
// Link outputs
// ----------------------------------------
assign link.cmd = cmdReg;
assign link.adrs = adrsReg;
assign link.wd = nextWord.data;
// Write strobe in the cycle of the last bit
assign link.wEd = wordEnd & ~inHeader & ~frameDone
	& ((cmdReg == cmdUsiWrite) | (cmdReg == cmdUfiWrite));
// Read strobe one cycle later with the address already advanced
assign link.rEd = rEdReg;

// ----------------------------------------
// Transmit shifter
// ----------------------------------------
logic [wordBit-2:0] txReg;

// Slot start loads a fresh word, otherwise shift MSB first
always_ff @(posedge sysClk)
begin
	if (sckFall)
	begin
		if (bitIdx == 5'd0)
			txReg <= link.misoWord[wordBit-2:0];
		else
			txReg <= {txReg[wordBit-3:0], 1'b0};
	end
end

always_ff @(posedge sysClk)
begin
	if (rst)
		miso <= 1'b0;
	else if (sckFall)
		miso <= (bitIdx == 5'd0) ? link.misoWord[wordBit-1] : txReg[wordBit-2];
end

endmodule

/* spiSignal/spiMasterByte.sv */
`timescale 1ns/1ps

module spiMasterByte
(
	input  logic sysClk,
	input  logic rst,
	input  logic divCke,
	input  logic [7:0] wd,
	input  logic wEd,
	input  logic misoIn,
	output logic sckOut,
	output logic mosiOut,
	output logic [7:0] rd,
	output logic intr
);

// ----------------------------------------
// Byte sequencer
// ----------------------------------------
logic busy;
// Half period counter, 16 per byte
logic [3:0] edgeCnt;
logic lastEdge;
// Transmit and receive shifters
logic [7:0] txReg;
logic [7:0] rxReg;

assign lastEdge = divCke & busy & (edgeCnt == 4'd15);

always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		busy <= 1'b0;
		edgeCnt <= '0;
		sckOut <= 1'b0;
		mosiOut <= 1'b0;
		intr <= 1'b0;
	end
	else
	begin
		intr <= 1'b0;
		if (!busy && wEd)
		begin
			// Start of byte with MSB already on mosi
			busy <= 1'b1;
			edgeCnt <= '0;
			sckOut <= 1'b0;
			mosiOut <= wd[7];
		end
		else if (busy && divCke)
		begin
			sckOut <= ~sckOut;
			edgeCnt <= edgeCnt + 4'd1;
			// Falling edge presents the next bit
			if (sckOut)
				mosiOut <= txReg[6];
			if (lastEdge)
			begin
				busy <= 1'b0;
				intr <= 1'b1;
			end
		end
	end
end

// ----------------------------------------
// Data shifters
// ----------------------------------------
always_ff @(posedge sysClk)
begin
	if (!busy && wEd)
		txReg <= wd;
	else if (busy && divCke && sckOut)
		txReg <= {txReg[6:0], 1'b0};
end

// Sample miso as sck goes high
always_ff @(posedge sysClk)
begin
	if (busy && divCke && !sckOut)
		rxReg <= {rxReg[6:0], misoIn};
end

// Result holds until the next byte ends
always_ff @(posedge sysClk)
begin
	if (lastEdge)
		rd <= rxReg;
end

endmodule

/* src/ckeGenerator.sv */
`timescale 1ns/1ps

module ckeGenerator import psramPkg::*;
(
	input  logic sysClk,
	input  logic rst,
	input  logic cke,
	input  logic [divBit-1:0] div,
	output logic divCke
);

// Divider value held locally
logic [divBit-1:0] divReg;
logic [divBit-1:0] cnt;

always_ff @(posedge sysClk)
begin
	divReg <= div;
end

// ----------------------------------------
// Down counter
// ----------------------------------------
always_ff @(posedge sysClk)
begin
	if (rst || !cke)
	begin
		cnt <= '0;
		divCke <= 1'b0;
	end
	else if (cnt == '0)
	begin
		// One pulse per div+1 cycles
		cnt <= divReg;
		divCke <= 1'b1;
	end
	else
	begin
		cnt <= cnt - 1'b1;
		divCke <= 1'b0;
	end
end

endmodule

/* src/spiBusMux.sv */
`timescale 1ns/1ps

module spiBusMux import psramPkg::*;
(
	input  logic sysClk,
	input  logic rst,
	input  logic [wordBit-1:0] usiRd,
	spiLinkIf.bus link,
	output logic [wordBit-1:0] usiWd,
	output logic [busAdrsBit-1:0] usiAdrs,
	output logic usiWEd,
	output logic [wordBit-1:0] ufiWd,
	output logic [wordBit-1:0] ufiAdrs,
	output logic ufiWEd,
	output logic ufiWVd
);

// ----------------------------------------
// Strobe routing
// ----------------------------------------
logic usiWrite;
logic ufiWrite;
// Read address is on the bus this cycle
logic rdPend;

assign usiWrite = link.wEd & (link.cmd == cmdUsiWrite);
assign ufiWrite = link.wEd & (link.cmd == cmdUfiWrite);

always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		usiWEd <= 1'b0;
		ufiWEd <= 1'b0;
		ufiWVd <= 1'b0;
		rdPend <= 1'b0;
	end
	else
	begin
		usiWEd <= usiWrite;
		ufiWEd <= ufiWrite;
		// Stream valid spans the whole stream frame
		ufiWVd <= (link.cmd == cmdUfiWrite);
		rdPend <= link.rEd;
	end
end

// ----------------------------------------
// Register bus payload
// ----------------------------------------
always_ff @(posedge sysClk)
begin
	if (usiWrite)
		usiWd <= link.wd;
end

// Shared by writes and reads
always_ff @(posedge sysClk)
begin
	if (usiWrite || link.rEd)
		usiAdrs <= link.adrs;
end

// ----------------------------------------
// Stream bus payload
// ----------------------------------------
// Word address to byte address
always_ff @(posedge sysClk)
begin
	if (ufiWrite)
	begin
		ufiWd <= link.wd;
		ufiAdrs <= {{(wordBit-busAdrsBit-2){1'b0}}, link.adrs, 2'b00};
	end
end

// ----------------------------------------
// Read capture
// ----------------------------------------
// usiRd answers combinationally to usiAdrs
always_ff @(posedge sysClk)
begin
	if (rdPend)
		link.misoWord <= usiRd;
end

endmodule

/* src/psramUnit.sv */
`timescale 1ns/1ps

module psramUnit import psramPkg::*;
(
	inout  wire spiSck,
	inout  wire spiMiso,
	inout  wire spiMosi,
	input  logic spiCs,
	input  logic mSSel,
	output logic spiConfigCs,
	output logic usiMonopoly,
	input  logic [wordBit-1:0] usiRd,
	output logic [wordBit-1:0] usiWd,
	output logic [busAdrsBit-1:0] usiAdrs,
	output logic usiWEd,
	output logic [wordBit-1:0] ufiWd,
	output logic [wordBit-1:0] ufiAdrs,
	output logic ufiWEd,
	output logic ufiWVd,
	input  logic spiEn,
	input  logic [divBit-1:0] spiDiv,
	input  logic [7:0] mWd,
	input  logic mSpiCs,
	input  logic mWEd,
	output logic [7:0] mRd,
	output logic mSpiIntr,
	input  logic sysClk,
	input  logic rst
);

// ----------------------------------------
// Mode and pin enables
// ----------------------------------------
logic slvEn;
logic frameCs;

always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		usiMonopoly <= 1'b0;
		slvEn <= 1'b0;
	end
	else
	begin
		// Master mode also owns the register bus
		usiMonopoly <= mSSel;
		slvEn <= ~mSSel & ~spiCs;
	end
end

// Slave receiver sits idle in master mode
assign frameCs = spiCs | usiMonopoly;
assign spiConfigCs = usiMonopoly ? mSpiCs : 1'b1;

// ----------------------------------------
// Master side
// ----------------------------------------
logic divCke;
logic mSck;
logic mMosi;

ckeGenerator spiCkeGen (.sysClk(sysClk), .rst(rst), .cke(spiEn), .div(spiDiv),
	.divCke(divCke));

spiMasterByte spiMaster (.sysClk(sysClk), .rst(rst), .divCke(divCke), .wd(mWd),
	.wEd(mWEd), .misoIn(spiMiso), .sckOut(mSck), .mosiOut(mMosi), .rd(mRd),
	.intr(mSpiIntr));

// ----------------------------------------
// Slave side
// ----------------------------------------
logic sMiso;

spiLinkIf link ();

spiSlaveFrame spiSlave (.sysClk(sysClk), .rst(rst), .sck(spiSck), .mosi(spiMosi),
	.cs(frameCs), .miso(sMiso), .link(link.frame));

spiBusMux spiMux (.sysClk(sysClk), .rst(rst), .usiRd(usiRd), .link(link.bus),
	.usiWd(usiWd), .usiAdrs(usiAdrs), .usiWEd(usiWEd), .ufiWd(ufiWd),
	.ufiAdrs(ufiAdrs), .ufiWEd(ufiWEd), .ufiWVd(ufiWVd));

// ----------------------------------------
// Tristate pins
// ----------------------------------------
assign spiSck = usiMonopoly ? mSck : 1'bz;
assign spiMosi = usiMonopoly ? mMosi : 1'bz;
// Miso only while the external host selects us
assign spiMiso = slvEn ? sMiso : 1'bz;

endmodule

/* verification/psramUnitTb.sv */
`timescale 1ns/1ps

module psramUnitTb import psramPkg::*;;

// ----------------------------------------
// DUT pins
// ----------------------------------------
logic sysClk;
logic rst;
logic spiCs;
logic mSSel;
logic spiEn;
logic [divBit-1:0] spiDiv;
logic [7:0] mWd;
logic mSpiCs;
logic mWEd;
logic spiConfigCs;
logic usiMonopoly;
logic [wordBit-1:0] usiRd;
logic [wordBit-1:0] usiWd;
logic [busAdrsBit-1:0] usiAdrs;
logic usiWEd;
logic [wordBit-1:0] ufiWd;
logic [wordBit-1:0] ufiAdrs;
logic ufiWEd;
logic ufiWVd;
logic [7:0] mRd;
logic mSpiIntr;
wire spiSck;
wire spiMosi;
wire spiMiso;

// Host side and external slave side pin drivers
logic hostDrive;
logic hostSck;
logic hostMosi;
logic slaveActive;
logic [7:0] slaveShift;

// Test list, USI memory and the host's own copy of it
logic [31:0] tests [0:255];
logic [31:0] usiMem [0:255];
logic [31:0] hostMem [0:255];
// UFI beats as {address, data}
logic [63:0] ufiBeats [$];

// Monitor state
int cycleCnt = 0;
int usiWriteCnt = 0;
int intrCnt = 0;
int sckEdgeCnt = 0;
int lastEdgeCycle = 0;
int curDiv = 0;
logic prevSck = 1'b0;
logic [7:0] mosiCap;

assign spiSck = hostDrive ? hostSck : 1'bz;
assign spiMosi = hostDrive ? hostMosi : 1'bz;
assign spiMiso = slaveActive ? slaveShift[7] : 1'bz;
// Combinational read port
assign usiRd = usiMem[usiAdrs[7:0]];

always #20 sysClk = ~sysClk;

psramUnit i_psramUnit (.spiSck(spiSck), .spiMiso(spiMiso), .spiMosi(spiMosi),
	.spiCs(spiCs), .mSSel(mSSel), .spiConfigCs(spiConfigCs), .usiMonopoly(usiMonopoly),
	.usiRd(usiRd), .usiWd(usiWd), .usiAdrs(usiAdrs), .usiWEd(usiWEd), .ufiWd(ufiWd),
	.ufiAdrs(ufiAdrs), .ufiWEd(ufiWEd), .ufiWVd(ufiWVd), .spiEn(spiEn), .spiDiv(spiDiv),
	.mWd(mWd), .mSpiCs(mSpiCs), .mWEd(mWEd), .mRd(mRd), .mSpiIntr(mSpiIntr),
	.sysClk(sysClk), .rst(rst));

// ----------------------------------------
// Error handling and checks
// ----------------------------------------
task stopRun();
	$display("tests failed");
	$fatal(1, "Run stopped at the first error");
endtask

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp)
	else
	begin
		$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
		stopRun();
	end
endtask

// Memory fill, every address bit shows up in the word
function automatic logic [31:0] fillWord(input int a);
	logic [7:0] b;
	b = a[7:0];
	return {8'hc3, b, ~b, b ^ 8'h5a};
endfunction

// ----------------------------------------
// Bus models and pin monitor
// ----------------------------------------
always @(negedge sysClk)
begin
	cycleCnt = cycleCnt + 1;
	// USI memory
	if (usiWEd === 1'b1)
	begin
		assert (usiAdrs < 256)
		else
		begin
			$display("USI write to address %h lies outside the memory model", usiAdrs);
			stopRun();
		end
		usiMem[usiAdrs[7:0]] = usiWd;
		usiWriteCnt = usiWriteCnt + 1;
	end
	// UFI monitor
	if (ufiWEd === 1'b1)
	begin
		checkValue("ufiWVd at ufiWEd", ufiWVd, 1'b1);
		ufiBeats.push_back({ufiAdrs, ufiWd});
	end
	if (mSpiIntr === 1'b1)
		intrCnt = intrCnt + 1;
	// Slave model for master mode, mode 0
	if (slaveActive && spiSck !== prevSck)
	begin
		if (sckEdgeCnt > 0)
			checkValue("sck edge spacing", cycleCnt - lastEdgeCycle, curDiv + 1);
		lastEdgeCycle = cycleCnt;
		sckEdgeCnt = sckEdgeCnt + 1;
		if (spiSck === 1'b1)
			mosiCap = {mosiCap[6:0], spiMosi};
		else
			slaveShift = {slaveShift[6:0], 1'b0};
	end
	prevSck = spiSck;
end

// ----------------------------------------
// Host tasks
// ----------------------------------------
task automatic setMode(input logic master);
	int waitCnt;
	waitCnt = 0;
	// Release the pins before the DUT takes them
	if (master)
		hostDrive = 1'b0;
	mSSel = master;
	while (usiMonopoly !== master)
	begin
		@(negedge sysClk);
		waitCnt = waitCnt + 1;
		if (waitCnt > 10)
		begin
			$display("Timeout waiting for usiMonopoly to follow mSSel");
			stopRun();
		end
	end
	hostSck = 1'b0;
	hostMosi = 1'b0;
	hostDrive = ~master;
	repeat (2) @(negedge sysClk);
endtask

// One 32 bit slot, 16 cycle sck period
task automatic shiftWord(input logic [31:0] txWord, output logic [31:0] rxWord);
	for (int i = 31; i >= 0; i--)
	begin
		hostSck = 1'b0;
		hostMosi = txWord[i];
		repeat (8) @(negedge sysClk);
		// Miso settled well before the rising edge
		rxWord[i] = spiMiso;
		hostSck = 1'b1;
		repeat (8) @(negedge sysClk);
	end
endtask

task automatic runFrame(input int ptr);
	logic [31:0] header;
	logic [31:0] rxWord;
	logic [31:0] txWord;
	logic [1:0] cmd;
	logic [15:0] adrs;
	logic [15:0] wordAdrs;
	int count;
	int nSend;
	int used;
	int usiBase;
	int expUsi;
	int expUfi;
	header = tests[ptr+1];
	nSend = tests[ptr+2];
	cmd = header[31:30];
	count = header[29:16];
	adrs = header[15:0];
	// Words past the count are dropped
	used = (count < nSend) ? count : nSend;
	setMode(1'b0);
	spiEn = 1'b0;
	checkValue("spiConfigCs", spiConfigCs, 1'b1);
	usiBase = usiWriteCnt;
	ufiBeats.delete();
	spiCs = 1'b0;
	repeat (4) @(negedge sysClk);
	shiftWord(header, rxWord);
	for (int i = 0; i < nSend; i++)
	begin
		txWord = (cmd == cmdUsiRead) ? 32'd0 : tests[ptr+3+i];
		shiftWord(txWord, rxWord);
		wordAdrs = adrs + i[15:0];
		if (cmd == cmdUsiRead && i < count)
		begin
			checkValue("spiMiso read word", rxWord, tests[ptr+3+i]);
			checkValue("spiMiso against host copy", rxWord, hostMem[wordAdrs[7:0]]);
		end
		// Stream valid only inside a stream frame
		if (cmd == cmdUfiWrite)
			checkValue("ufiWVd", ufiWVd, 1'b1);
		else
			checkValue("ufiWVd", ufiWVd, 1'b0);
		if (cmd == cmdUsiWrite && i < count)
			hostMem[wordAdrs[7:0]] = txWord;
	end
	hostSck = 1'b0;
	repeat (8) @(negedge sysClk);
	spiCs = 1'b1;
	repeat (8) @(negedge sysClk);
	checkValue("ufiWVd after cs rise", ufiWVd, 1'b0);
	// Bus activity of the frame
	expUsi = (cmd == cmdUsiWrite) ? used : 0;
	expUfi = (cmd == cmdUfiWrite) ? used : 0;
	checkValue("usiWEd count", usiWriteCnt - usiBase, expUsi);
	checkValue("ufiWEd count", ufiBeats.size(), expUfi);
	for (int i = 0; i < expUfi; i++)
	begin
		wordAdrs = adrs + i[15:0];
		checkValue("ufiAdrs", ufiBeats[i][63:32], {14'd0, wordAdrs, 2'b00});
		checkValue("ufiWd", ufiBeats[i][31:0], tests[ptr+3+i]);
	end
	for (int a = 0; a < 256; a++)
		checkValue($sformatf("usiMem[%0d]", a), usiMem[a], hostMem[a]);
endtask

task automatic runByte(input int ptr);
	logic [7:0] wdByte;
	logic [7:0] slvByte;
	logic csLevel;
	int intrBase;
	int waitCnt;
	int limit;
	curDiv = tests[ptr+1];
	wdByte = tests[ptr+2][7:0];
	slvByte = tests[ptr+3][7:0];
	csLevel = tests[ptr+4][0];
	setMode(1'b1);
	// Divider restarts from a cleared counter
	spiEn = 1'b0;
	spiDiv = curDiv[divBit-1:0];
	mSpiCs = csLevel;
	repeat (3) @(negedge sysClk);
	checkValue("spiConfigCs", spiConfigCs, csLevel);
	checkValue("usiMonopoly", usiMonopoly, 1'b1);
	spiEn = 1'b1;
	sckEdgeCnt = 0;
	mosiCap = 8'd0;
	intrBase = intrCnt;
	// Slave presents its MSB before the first rising edge
	slaveShift = slvByte;
	slaveActive = 1'b1;
	mWd = wdByte;
	mWEd = 1'b1;
	@(negedge sysClk);
	mWEd = 1'b0;
	limit = 16 * (curDiv + 1) + 40;
	waitCnt = 0;
	while (mSpiIntr !== 1'b1)
	begin
		@(negedge sysClk);
		waitCnt = waitCnt + 1;
		if (waitCnt > limit)
		begin
			$display("Timeout waiting for mSpiIntr after mWEd");
			stopRun();
		end
	end
	// Last sck edge lands together with the interrupt
	repeat (4) @(negedge sysClk);
	checkValue("mRd", mRd, slvByte);
	checkValue("spiMosi byte", mosiCap, wdByte);
	checkValue("sck edge count", sckEdgeCnt, 16);
	checkValue("mSpiIntr pulse count", intrCnt - intrBase, 1);
	checkValue("spiConfigCs", spiConfigCs, csLevel);
	slaveActive = 1'b0;
	spiEn = 1'b0;
endtask

// ----------------------------------------
// Main sequence
// ----------------------------------------
initial
begin
	int ptr;
	sysClk = 1'b0;
	rst = 1'b1;
	spiCs = 1'b1;
	mSSel = 1'b0;
	spiEn = 1'b0;
	spiDiv = '0;
	mWd = 8'd0;
	mSpiCs = 1'b1;
	mWEd = 1'b0;
	hostDrive = 1'b1;
	hostSck = 1'b0;
	hostMosi = 1'b0;
	slaveActive = 1'b0;
	slaveShift = 8'd0;
	for (int a = 0; a < 256; a++)
	begin
		usiMem[a] = fillWord(a);
		hostMem[a] = fillWord(a);
	end
	$readmemh("verification/psramUnitTests.txt", tests);
	repeat (5) @(negedge sysClk);
	rst = 1'b0;
	@(negedge sysClk);
	// Idle levels after reset
	checkValue("usiWEd", usiWEd, 1'b0);
	checkValue("ufiWEd", ufiWEd, 1'b0);
	checkValue("ufiWVd", ufiWVd, 1'b0);
	checkValue("mSpiIntr", mSpiIntr, 1'b0);
	checkValue("usiMonopoly", usiMonopoly, 1'b0);
	checkValue("spiConfigCs", spiConfigCs, 1'b1);
	ptr = 0;
	while (tests[ptr] !== 32'd0)
	begin
		if (ptr > 240)
		begin
			$display("Test list has no end marker");
			stopRun();
		end
		if (tests[ptr] === 32'd1)
		begin
			runFrame(ptr);
			ptr = ptr + 3 + tests[ptr+2];
		end
		else if (tests[ptr] === 32'd2)
		begin
			runByte(ptr);
			ptr = ptr + 5;
		end
		else
		begin
			$display("Unknown operation %h at entry %0d of the test list", tests[ptr], ptr);
			stopRun();
		end
	end
	$display("all tests passed");
	$finish;
end

endmodule

/* verification/psramUnitTests.txt */
// Op 1 is a slave frame with header, number of words sent, then data or expected read words
// Op 2 is a master byte with divider, mWd, byte returned on miso and mSpiCs level
// Header holds cmd in 31:30, word count in 29:16 and start address in 15:0, op 0 ends the list

// USI write of three words at 0x0010
00000001 00030010 00000003
12345678 9abcdef0 0badf00d

// USI write counting two words at 0x00fe with one extra word sent
00000001 000200fe 00000003
a5a55a5a 01020304 deadbeef

// USI write of a single word at 0x0080
00000001 00010080 00000001
cafe0080

// Read back all three regions
00000001 40030010 00000003
12345678 9abcdef0 0badf00d
00000001 400200fe 00000002
a5a55a5a 01020304
00000001 40010080 00000001
cafe0080

// UFI stream of four words at word address 0x0120
00000001 80040120 00000004
11110000 22220001 33330002 44440003

// UFI stream counting two words with a third sent
00000001 80020008 00000003
55550000 66660001 77770002

// Reserved command with two words sent
00000001 c0020040 00000002
ffff0000 eeee0001

// Master bytes with several dividers
00000002 00000000 000000a5 0000003c 00000000
00000002 00000001 0000005a 000000c3 00000001
00000002 00000003 000000f0 00000081 00000000
00000002 00000006 00000017 000000e8 00000000

// Slave mode again with a last read
00000001 40030010 00000003
12345678 9abcdef0 0badf00d

// End of list
00000000

/* psramUnit.f */
common/psramPkg.sv
common/spiLinkIf.sv
spiSignal/spiSlaveFrame.sv
spiSignal/spiMasterByte.sv
src/ckeGenerator.sv
src/spiBusMux.sv
src/psramUnit.sv
verification/psramUnitTb.sv

/* Bender.yml */
package:
  name: psramUnit

sources:
  - files:
      - common/psramPkg.sv
      - common/spiLinkIf.sv
      - spiSignal/spiSlaveFrame.sv
      - spiSignal/spiMasterByte.sv
      - src/ckeGenerator.sv
      - src/spiBusMux.sv
      - src/psramUnit.sv
  - target: test
    files:
      - verification/psramUnitTb.sv
